// ==== frameBuffer_config.svh ====
`ifndef FRAME_BUFFER_CONFIG_SVH
`define FRAME_BUFFER_CONFIG_SVH

////////////////////////////////////////
// Screen geometry
////////////////////////////////////////

// Width of the horizontal screen coordinate
`define FB_X_BITS 5
// Width of the vertical screen coordinate
`define FB_Y_BITS 4
// Word address into the pixel memory, one pixel per word
`define FB_ADDR_BITS 8

////////////////////////////////////////
// Pixel layout
////////////////////////////////////////

// RGBA channels, each one held in its own lane memory
`define FB_SUB_PIXELS 4
`define FB_SUB_PIXEL_BITS 8

`endif

// ==== frameBufferPkg.sv ====
`include "frameBuffer_config.svh"

package frameBufferPkg;

    // Basic vectors
    typedef logic [`FB_SUB_PIXEL_BITS - 1 : 0] subPixel_t;
    typedef logic [`FB_SUB_PIXELS * `FB_SUB_PIXEL_BITS - 1 : 0] pixel_t;
    typedef logic [`FB_SUB_PIXELS - 1 : 0] laneMask_t;
    typedef logic [`FB_X_BITS - 1 : 0] screenX_t;
    typedef logic [`FB_Y_BITS - 1 : 0] screenY_t;
    typedef logic [`FB_ADDR_BITS - 1 : 0] fbAddr_t;

    // Static configuration levels
    typedef struct packed {
        logic      enable;
        pixel_t    clearColor;
        logic      enableScissor;
        screenX_t  scissorStartX;
        screenY_t  scissorStartY;
        screenX_t  scissorEndX;
        screenY_t  scissorEndY;
        screenX_t  xResolution;
        screenY_t  yResolution;
        laneMask_t mask;
    } fbConfig_t;

    // Fragment write, addr is the memory word and screenX/Y feed the scissor
    typedef struct packed {
        logic     valid;
        logic     strb;
        fbAddr_t  addr;
        pixel_t   data;
        screenX_t screenX;
        screenY_t screenY;
    } fragWrite_t;

    // Fragment read request and its result
    typedef struct packed {
        logic    valid;
        logic    last;
        fbAddr_t addr;
    } fragRead_t;

    typedef struct packed {
        logic   valid;
        logic   last;
        pixel_t data;
    } fragResult_t;

    // Write port of a single channel lane
    typedef struct packed {
        logic      write;
        fbAddr_t   addr;
        subPixel_t data;
    } laneWrite_t;

    // Stream master outputs
    typedef struct packed {
        logic   tvalid;
        logic   tlast;
        pixel_t tdata;
    } fbStream_t;

    // Command sequencer states
    typedef enum logic [1 : 0] {
        WaitForCommand,
        MemcpyInit,
        Memcpy,
        Memset
    } cmdState_t;

endpackage

// ==== fbCommandSequencer.sv ====
`include "frameBuffer_config.svh"

module fbCommandSequencer
    import frameBufferPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  fbConfig_t  conf,
    input  fragWrite_t fragWrite,
    input  fbAddr_t    fragReadAddr,
    input  logic       apply,
    input  logic       cmdCommit,
    input  logic       cmdMemset,
    input  logic       streamReady,
    output logic       applied,
    output logic       streamValid,
    output logic       streamLast,
    output laneWrite_t laneWrite [`FB_SUB_PIXELS],
    output fbAddr_t    laneReadAddr
);

    // Scissor test over a half open rectangle
    function automatic logic scissorPass(fbConfig_t c, screenX_t x, screenY_t y);
        logic inX;
        logic inY;
        inX = (x >= c.scissorStartX) && (x < c.scissorEndX);
        inY = (y >= c.scissorStartY) && (y < c.scissorEndY);
        return !c.enableScissor || (inX && inY);
    endfunction

    ////////////////////////////////////////
    // Command state
    ////////////////////////////////////////

    cmdState_t state;

    // Walks the memory for both commit and memset
    fbAddr_t   cmdIndex;
    fbAddr_t   cmdIndexNext;
    // Index of the final pixel, latched while idle
    fbAddr_t   lastIndex;
    // Pixel count, 256 wraps to 0 which still gives lastIndex 255
    fbAddr_t   fbSize;

    // Screen position of cmdIndex during memset
    screenX_t  memsetX;
    screenX_t  memsetXNext;
    screenY_t  memsetY;
    logic      memsetPending;

    logic      cmdActive;
    logic      commitActive;
    logic      fragScissor;
    logic      memsetScissor;
    logic      fragWriteEnable;

    assign cmdIndexNext = cmdIndex + fbAddr_t'(1);
    assign memsetXNext  = memsetX + screenX_t'(1);
    assign fbSize       = fbAddr_t'(conf.xResolution) * fbAddr_t'(conf.yResolution);

    assign cmdActive    = (state != WaitForCommand);
    assign commitActive = (state == MemcpyInit) || (state == Memcpy);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= WaitForCommand;
            applied       <= 1'b1;
            streamValid   <= 1'b0;
            streamLast    <= 1'b0;
            memsetPending <= 1'b0;
            cmdIndex      <= '0;
            lastIndex     <= '0;
            memsetX       <= '0;
            memsetY       <= '0;
        end
        else
        begin
            case (state)
                WaitForCommand:
                begin
                    // Preload the walk
                    // Index 0 is the top row, which is yResolution - 1 in screen space
                    cmdIndex  <= '0;
                    memsetX   <= '0;
                    memsetY   <= conf.yResolution - screenY_t'(1);
                    lastIndex <= fbSize - fbAddr_t'(1);
                    applied   <= !apply;
                    if (apply)
                    begin
                        memsetPending <= cmdMemset;
                        // Commit goes first so the old frame leaves before the clear
                        if (cmdCommit)
                        begin
                            state <= MemcpyInit;
                        end
                        else if (cmdMemset)
                        begin
                            state <= Memset;
                        end
                    end
                end

                MemcpyInit:
                begin
                    // Lane memories are reading index 0 during this cycle
                    streamValid <= 1'b1;
                    streamLast  <= (lastIndex == '0);
                    state       <= Memcpy;
                end

                Memcpy:
                begin
                    if (streamReady)
                    begin
                        cmdIndex   <= cmdIndexNext;
                        streamLast <= (cmdIndexNext == lastIndex);
                        // Beat accepted on the final pixel
                        if (cmdIndex == lastIndex)
                        begin
                            streamValid <= 1'b0;
                            streamLast  <= 1'b0;
                            cmdIndex    <= '0;
                            state       <= memsetPending ? Memset : WaitForCommand;
                        end
                    end
                end

                Memset:
                begin
                    cmdIndex <= cmdIndexNext;
                    // Row wraps left to right, rows go downwards in screen space
                    if (memsetXNext == conf.xResolution)
                    begin
                        memsetX <= '0;
                        memsetY <= memsetY - screenY_t'(1);
                    end
                    else
                    begin
                        memsetX <= memsetXNext;
                    end
                    if (cmdIndex == lastIndex)
                    begin
                        state <= WaitForCommand;
                    end
                end

                default:
                begin
                    state <= WaitForCommand;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Memory port multiplexer
    ////////////////////////////////////////

    assign fragScissor     = scissorPass(conf, fragWrite.screenX, fragWrite.screenY);
    assign memsetScissor   = scissorPass(conf, memsetX, memsetY);
    assign fragWriteEnable = fragWrite.valid && fragWrite.strb && conf.enable && fragScissor;

    always_comb
    begin
        for (int i = 0; i < `FB_SUB_PIXELS; i++)
        begin
            if (cmdActive)
            begin
                // Fragment writes are dropped while a command owns the memory
                laneWrite[i].write = (state == Memset) && conf.mask[i] && memsetScissor;
                laneWrite[i].addr  = cmdIndex;
                laneWrite[i].data  =
                    conf.clearColor[i * `FB_SUB_PIXEL_BITS +: `FB_SUB_PIXEL_BITS];
            end
            else
            begin
                laneWrite[i].write = fragWriteEnable && conf.mask[i];
                laneWrite[i].addr  = fragWrite.addr;
                laneWrite[i].data  =
                    fragWrite.data[i * `FB_SUB_PIXEL_BITS +: `FB_SUB_PIXEL_BITS];
            end
        end
    end

    // Look one pixel ahead on an accepted beat so tdata follows the index
    always_comb
    begin
        if (commitActive)
        begin
            laneReadAddr = ((state == Memcpy) && streamReady) ? cmdIndexNext : cmdIndex;
        end
        else
        begin
            laneReadAddr = fragReadAddr;
        end
    end

endmodule

// ==== fbLaneRam.sv ====
`include "frameBuffer_config.svh"

module fbLaneRam
    import frameBufferPkg::*;
(
    input  logic       clk,
    input  laneWrite_t laneWrite,
    input  fbAddr_t    readAddr,
    output subPixel_t  readData
);

    // One channel of every pixel on screen
    subPixel_t mem [2 ** `FB_ADDR_BITS];

    // Write port
    always_ff @(posedge clk)
    begin
        if (laneWrite.write)
        begin
            mem[laneWrite.addr] <= laneWrite.data;
        end
    end

    // Registered read port
    // Same edge collision returns the old word
    always_ff @(posedge clk)
    begin
        readData <= mem[readAddr];
    end

endmodule

// ==== fbReadout.sv ====
`include "frameBuffer_config.svh"

module fbReadout
    import frameBufferPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  subPixel_t   laneData [`FB_SUB_PIXELS],
    input  fragRead_t   fragRead,
    output pixel_t      streamData,
    output fragResult_t fragResult
);

    pixel_t pixel;

    // First stage runs alongside the lane read register
    logic   validDelay;
    logic   lastDelay;

    // Second stage
    logic   resultValid;
    logic   resultLast;
    pixel_t resultData;

    // Lane 0 lands in the low byte
    always_comb
    begin
        for (int i = 0; i < `FB_SUB_PIXELS; i++)
        begin
            pixel[i * `FB_SUB_PIXEL_BITS +: `FB_SUB_PIXEL_BITS] = laneData[i];
        end
    end

    // Stream data is the raw lane output, sequencer keeps the address steady
    assign streamData = pixel;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            validDelay  <= 1'b0;
            lastDelay   <= 1'b0;
            resultValid <= 1'b0;
            resultLast  <= 1'b0;
        end
        else
        begin
            validDelay  <= fragRead.valid;
            lastDelay   <= fragRead.last;
            resultValid <= validDelay;
            resultLast  <= lastDelay;
        end
    end

    always_ff @(posedge clk)
    begin
        resultData <= pixel;
    end

    assign fragResult = '{valid: resultValid, last: resultLast, data: resultData};

endmodule

// ==== frameBufferTop.sv ====
`include "frameBuffer_config.svh"

module frameBufferTop
    import frameBufferPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  fbConfig_t   conf,
    input  fragWrite_t  fragWrite,
    input  fragRead_t   fragRead,
    output fragResult_t fragResult,
    input  logic        apply,
    output logic        applied,
    input  logic        cmdCommit,
    input  logic        cmdMemset,
    output fbStream_t   stream,
    input  logic        streamReady
);

    ////////////////////////////////////////
    // Lane buses
    ////////////////////////////////////////

    laneWrite_t laneWrite [`FB_SUB_PIXELS];
    fbAddr_t    laneReadAddr;
    subPixel_t  laneData [`FB_SUB_PIXELS];

    // Stream pieces from sequencer and readout
    logic       streamValid;
    logic       streamLast;
    pixel_t     streamData;

    // Commands, scissor and port arbitration
    fbCommandSequencer i_sequencer (
        .clk          (clk),
        .reset        (reset),
        .conf         (conf),
        .fragWrite    (fragWrite),
        .fragReadAddr (fragRead.addr),
        .apply        (apply),
        .cmdCommit    (cmdCommit),
        .cmdMemset    (cmdMemset),
        .streamReady  (streamReady),
        .applied      (applied),
        .streamValid  (streamValid),
        .streamLast   (streamLast),
        .laneWrite    (laneWrite),
        .laneReadAddr (laneReadAddr)
    );

    // One memory per channel, all sharing the read address
    for (genvar lane = 0; lane < `FB_SUB_PIXELS; lane++)
    begin : g_lane
        fbLaneRam i_lane (
            .clk       (clk),
            .laneWrite (laneWrite[lane]),
            .readAddr  (laneReadAddr),
            .readData  (laneData[lane])
        );
    end

    // Pixel assembly and fragment read pipeline
    fbReadout i_readout (
        .clk        (clk),
        .reset      (reset),
        .laneData   (laneData),
        .fragRead   (fragRead),
        .streamData (streamData),
        .fragResult (fragResult)
    );

    assign stream = '{tvalid: streamValid, tlast: streamLast, tdata: streamData};

endmodule

// ==== frameBuffer_chk.sv ====
`include "frameBuffer_config.svh"

module frameBuffer_chk
    import frameBufferPkg::*;
(
    input logic      clk,
    input logic      reset,
    input fbStream_t stream,
    input logic      streamReady,
    input logic      applied
);

    ////////////////////////////////////////
    // Reset state
    ////////////////////////////////////////

    resetIdle: assert property (@(posedge clk) reset |=> !stream.tvalid && !stream.tlast)
        else $error("Stream active in the cycle after reset");

    // Ready for a command straight out of reset
    resetApplied: assert property (@(posedge clk) reset |=> applied)
        else $error("applied low in the cycle after reset");

    ////////////////////////////////////////
    // Stream handshake
    ////////////////////////////////////////

    // A stalled beat holds still
    stallHold: assert property (@(posedge clk) disable iff (reset)
        stream.tvalid && !streamReady |=>
            stream.tvalid && $stable(stream.tdata) && $stable(stream.tlast))
        else $error("Stream beat changed while stalled");

    lastNeedsValid: assert property (@(posedge clk) disable iff (reset)
        stream.tlast |-> stream.tvalid)
        else $error("tlast high without tvalid");

endmodule

bind frameBufferTop frameBuffer_chk i_chk (
    .clk         (clk),
    .reset       (reset),
    .stream      (stream),
    .streamReady (streamReady),
    .applied     (applied)
);

// ==== frameBufferTb.sv ====
`include "frameBuffer_config.svh"

module frameBufferTb
    import frameBufferPkg::*;
();

    localparam int screenW     = 16;
    localparam int screenH     = 8;
    localparam int pixels      = screenW * screenH;
    localparam int resetCycles = 8;
    localparam int numOps      = 16;

    typedef enum logic [2 : 0] {
        OpConfig,
        OpWrite,
        OpRead,
        OpMemset,
        OpCommit,
        OpCommitMemset
    } opKind_t;

    // One table row, config fields only matter for OpConfig
    typedef struct packed {
        opKind_t   op;
        fbAddr_t   addr;
        int        count;
        logic      backPressure;
        int        expBeats;
        logic      enable;
        logic      scissorOn;
        screenX_t  startX;
        screenY_t  startY;
        screenX_t  endX;
        screenY_t  endY;
        laneMask_t mask;
        pixel_t    color;
    } opRow_t;

    logic        clk = 1'b0;
    logic        reset;
    fbConfig_t   conf;
    fragWrite_t  fragWrite;
    fragRead_t   fragRead;
    fragResult_t fragResult;
    logic        apply;
    logic        applied;
    logic        cmdCommit;
    logic        cmdMemset;
    fbStream_t   stream;
    logic        streamReady;

    // Reference screen and the frame a commit is expected to send
    pixel_t      refMem [2 ** `FB_ADDR_BITS];
    pixel_t      streamExp [2 ** `FB_ADDR_BITS];
    opRow_t      ops [numOps];
    int          cycles = 0;
    int          cycleLimit = 0;

    frameBufferTop i_dut (
        .clk         (clk),
        .reset       (reset),
        .conf        (conf),
        .fragWrite   (fragWrite),
        .fragRead    (fragRead),
        .fragResult  (fragResult),
        .apply       (apply),
        .applied     (applied),
        .cmdCommit   (cmdCommit),
        .cmdMemset   (cmdMemset),
        .stream      (stream),
        .streamReady (streamReady)
    );

    always #2 clk = ~clk;

    // Run length guard
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycleLimit)
        begin
            abortRun($sformatf("Timeout: run still going after %0d cycles", cycleLimit));
        end
    end

    ////////////////////////////////////////
    // Reporting and compares
    ////////////////////////////////////////

    task automatic abortRun(string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic checkPixel(string what, pixel_t got, pixel_t exp);
        if (got !== exp)
        begin
            abortRun($sformatf("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkLast(string what, logic got, logic exp);
        if (got !== exp)
        begin
            abortRun($sformatf("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkValid(string what, logic got, logic exp);
        if (got !== exp)
        begin
            abortRun($sformatf("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Index 0 is the top left pixel, top row is y = screenH - 1
    function automatic screenX_t indexX(int idx);
        return screenX_t'(idx % screenW);
    endfunction

    function automatic screenY_t indexY(int idx);
        return screenY_t'(screenH - 1 - idx / screenW);
    endfunction

    // Half open rectangle on both axes
    function automatic logic insideScissor(screenX_t x, screenY_t y);
        if (!conf.enableScissor)
        begin
            return 1'b1;
        end
        return (x >= conf.scissorStartX) && (x < conf.scissorEndX)
            && (y >= conf.scissorStartY) && (y < conf.scissorEndY);
    endfunction

    // Only channels with their mask bit set take the new value
    function automatic void mergePixel(fbAddr_t addr, pixel_t value);
        for (int lane = 0; lane < `FB_SUB_PIXELS; lane++)
        begin
            if (conf.mask[lane])
            begin
                refMem[addr][lane * 8 +: 8] = value[lane * 8 +: 8];
            end
        end
    endfunction

    function automatic void clearReference();
        for (int i = 0; i < pixels; i++)
        begin
            if (insideScissor(indexX(i), indexY(i)))
            begin
                mergePixel(fbAddr_t'(i), conf.clearColor);
            end
        end
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic idleInputs();
        fragWrite.valid = 1'b0;
        fragWrite.strb  = 1'b0;
        fragRead        = '0;
        apply           = 1'b0;
        cmdCommit       = 1'b0;
        cmdMemset       = 1'b0;
    endtask

    task automatic applyConfig(opRow_t row);
        @(posedge clk);
        #1;
        idleInputs();
        conf.enable        = row.enable;
        conf.clearColor    = row.color;
        conf.enableScissor = row.scissorOn;
        conf.scissorStartX = row.startX;
        conf.scissorStartY = row.startY;
        conf.scissorEndX   = row.endX;
        conf.scissorEndY   = row.endY;
        conf.mask          = row.mask;
    endtask

    // Random pixels to consecutive addresses, one per cycle
    task automatic writeFragments(opRow_t row);
        fbAddr_t addr;
        pixel_t  data;
        for (int k = 0; k < row.count; k++)
        begin
            @(posedge clk);
            #1;
            idleInputs();
            addr = row.addr + fbAddr_t'(k);
            data = $urandom;
            fragWrite.valid   = 1'b1;
            fragWrite.strb    = 1'b1;
            fragWrite.addr    = addr;
            fragWrite.data    = data;
            fragWrite.screenX = indexX(int'(addr));
            fragWrite.screenY = indexY(int'(addr));
            if (conf.enable && insideScissor(indexX(int'(addr)), indexY(int'(addr))))
            begin
                mergePixel(addr, data);
            end
        end
    endtask

    // Back to back reads, each result shows two drive steps later
    task automatic readFragments(opRow_t row);
        int      issued;
        fbAddr_t addr;
        for (int k = 0; k < row.count + 2; k++)
        begin
            @(posedge clk);
            #1;
            idleInputs();
            if (k < row.count)
            begin
                fragRead.valid = 1'b1;
                fragRead.last  = (k == row.count - 1);
                fragRead.addr  = row.addr + fbAddr_t'(k);
            end
            @(negedge clk);
            issued = k - 2;
            if (issued >= 0)
            begin
                addr = row.addr + fbAddr_t'(issued);
                checkValid("fragResult.valid", fragResult.valid, 1'b1);
                checkPixel("fragResult.data", fragResult.data, refMem[addr]);
                checkLast("fragResult.last", fragResult.last, issued == row.count - 1);
            end
            else
            begin
                checkValid("fragResult.valid", fragResult.valid, 1'b0);
            end
        end
    endtask

    // Commit, memset or both, finished when applied comes back
    task automatic runCommand(opRow_t row);
        int   beats;
        logic done;
        for (int i = 0; i < pixels; i++)
        begin
            streamExp[fbAddr_t'(i)] = refMem[fbAddr_t'(i)];
        end
        @(posedge clk);
        #1;
        idleInputs();
        cmdCommit = (row.op != OpMemset);
        cmdMemset = (row.op != OpCommit);
        apply     = 1'b1;
        beats     = 0;
        done      = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            #1;
            idleInputs();
            streamReady = row.backPressure ? (($urandom % 4) != 0) : 1'b1;
            @(negedge clk);
            // A beat moves on the coming edge
            if (stream.tvalid && streamReady)
            begin
                if (beats >= pixels)
                begin
                    abortRun("Stream sent more beats than the screen holds");
                end
                checkPixel("stream.tdata", stream.tdata, streamExp[fbAddr_t'(beats)]);
                checkLast("stream.tlast", stream.tlast, beats == pixels - 1);
                beats++;
            end
            done = applied;
        end
        if (beats != row.expBeats)
        begin
            abortRun($sformatf("Stream ended after %0d beats instead of %0d",
                beats, row.expBeats));
        end
        if (row.op != OpCommit)
        begin
            clearReference();
        end
    endtask

    function automatic opRow_t cfgRow(logic en, logic sc, screenX_t sx, screenY_t sy,
        screenX_t ex, screenY_t ey, laneMask_t mask, pixel_t color);
        opRow_t r;
        r           = '0;
        r.op        = OpConfig;
        r.enable    = en;
        r.scissorOn = sc;
        r.startX    = sx;
        r.startY    = sy;
        r.endX      = ex;
        r.endY      = ey;
        r.mask      = mask;
        r.color     = color;
        return r;
    endfunction

    function automatic opRow_t cmdRow(opKind_t op, fbAddr_t addr, int count, logic bp,
        int expBeats);
        opRow_t r;
        r              = '0;
        r.op           = op;
        r.addr         = addr;
        r.count        = count;
        r.backPressure = bp;
        r.expBeats     = expBeats;
        return r;
    endfunction

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        int total;
        void'($urandom(32'h06e0102c));

        // Clear, then stream the cleared frame
        ops[0]  = cfgRow(1'b1, 1'b0, 5'd0, 4'd0, 5'd0, 4'd0, 4'b1111, 32'h1122_3344);
        ops[1]  = cmdRow(OpMemset, 8'h00, 0, 1'b0, 0);
        ops[2]  = cmdRow(OpCommit, 8'h00, 0, 1'b0, pixels);
        // Masked, scissored writes read back
        ops[3]  = cfgRow(1'b1, 1'b1, 5'd4, 4'd2, 5'd12, 4'd6, 4'b0101, 32'h0);
        ops[4]  = cmdRow(OpWrite, 8'h10, 64, 1'b0, 0);
        ops[5]  = cmdRow(OpRead, 8'h10, 64, 1'b0, 0);
        // Scissored clear shown by a stalled commit
        ops[6]  = cfgRow(1'b1, 1'b1, 5'd2, 4'd1, 5'd9, 4'd7, 4'b1110, 32'hA5C3_0F96);
        ops[7]  = cmdRow(OpMemset, 8'h00, 0, 1'b0, 0);
        ops[8]  = cmdRow(OpCommit, 8'h00, 0, 1'b1, pixels);
        // Writes with the framebuffer disabled
        ops[9]  = cfgRow(1'b0, 1'b0, 5'd0, 4'd0, 5'd0, 4'd0, 4'b1111, 32'h0);
        ops[10] = cmdRow(OpWrite, 8'h00, 32, 1'b0, 0);
        ops[11] = cmdRow(OpRead, 8'h00, 32, 1'b0, 0);
        // Old frame leaves before the clear
        ops[12] = cfgRow(1'b1, 1'b0, 5'd0, 4'd0, 5'd0, 4'd0, 4'b1111, 32'h5A3C_96E1);
        ops[13] = cmdRow(OpWrite, 8'h40, 8, 1'b0, 0);
        ops[14] = cmdRow(OpCommitMemset, 8'h00, 0, 1'b1, pixels);
        ops[15] = cmdRow(OpCommit, 8'h00, 0, 1'b0, pixels);

        total = numOps;
        for (int r = 0; r < numOps; r++)
        begin
            total += ops[r].count + ops[r].expBeats;
            if (ops[r].op == OpMemset || ops[r].op == OpCommitMemset)
            begin
                total += pixels;
            end
        end
        cycleLimit = resetCycles + 4 * total;

        reset       = 1'b1;
        conf        = '0;
        fragWrite   = '0;
        fragRead    = '0;
        apply       = 1'b0;
        cmdCommit   = 1'b0;
        cmdMemset   = 1'b0;
        streamReady = 1'b1;
        conf.xResolution = screenX_t'(screenW);
        conf.yResolution = screenY_t'(screenH);
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int r = 0; r < numOps; r++)
        begin
            case (ops[r].op)
                OpConfig: applyConfig(ops[r]);
                OpWrite:  writeFragments(ops[r]);
                OpRead:   readFragments(ops[r]);
                default:  runCommand(ops[r]);
            endcase
        end

        @(posedge clk);
        #1;
        idleInputs();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
frameBufferPkg.sv
fbCommandSequencer.sv
fbLaneRam.sv
fbReadout.sv
frameBufferTop.sv
frameBuffer_chk.sv
frameBufferTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the framebuffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module frameBufferTb -f all.f
./obj_dir/VframeBufferTb
